// ==== rtc_pkg.sv ====
package rtc_pkg;

  localparam int clk_mhz      = 25;                 // board oscillator
  localparam int scl_quarter  = clk_mhz * 10 / 4;   // 62 cycles per quarter, about 100 khz
  localparam int debounce_len = 256;                // stable cycles before a level is taken

  localparam logic [6:0] dev_addr_rtc = 7'h6F;      // rtc register block

  // register port map of the master
  localparam logic [1:0] reg_wdata = 2'd0;
  localparam logic [1:0] reg_raddr = 2'd1;
  localparam logic [1:0] reg_dev   = 2'd2;
  localparam logic [1:0] reg_cmd   = 2'd3;

  // bit engine commands
  localparam logic [2:0] cmd_idle  = 3'd0;
  localparam logic [2:0] cmd_start = 3'd1;          // also used as repeated start
  localparam logic [2:0] cmd_stop  = 3'd2;
  localparam logic [2:0] cmd_write = 3'd3;
  localparam logic [2:0] cmd_read  = 3'd4;

  // transaction sequencer states
  localparam logic [3:0] st_idle   = 4'd0;
  localparam logic [3:0] st_start  = 4'd1;
  localparam logic [3:0] st_addr_w = 4'd2;
  localparam logic [3:0] st_reg    = 4'd3;
  localparam logic [3:0] st_data_w = 4'd4;
  localparam logic [3:0] st_rstart = 4'd5;
  localparam logic [3:0] st_addr_r = 4'd6;
  localparam logic [3:0] st_data_r = 4'd7;
  localparam logic [3:0] st_stop   = 4'd8;

  // address byte on the wire, seen raw or as fields
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      logic [6:0] dev;
      logic       rw;                               // 1 reads
    } f;
  } i2c_addr_byte_u;

  localparam logic [15:0] color_fg = 16'hFFFF;      // white
  localparam logic [15:0] color_bg = 16'h0000;      // black

  localparam int cell_w  = 6;                       // character cell incl. spacing
  localparam int cell_h  = 8;
  localparam int glyph_w = 5;
  localparam int glyph_h = 7;

  // rows top to bottom, leftmost column in the msb of each row
  localparam logic [34:0] hex_glyph [16] = '{
    35'b01110_10001_10011_10101_11001_10001_01110,  // 0
    35'b00100_01100_00100_00100_00100_00100_01110,  // 1
    35'b01110_10001_00001_00010_00100_01000_11111,  // 2
    35'b11111_00010_00100_00010_00001_10001_01110,  // 3
    35'b00010_00110_01010_10010_11111_00010_00010,  // 4
    35'b11111_10000_11110_00001_00001_10001_01110,  // 5
    35'b00110_01000_10000_11110_10001_10001_01110,  // 6
    35'b11111_00001_00010_00100_01000_01000_01000,  // 7
    35'b01110_10001_10001_01110_10001_10001_01110,  // 8
    35'b01110_10001_10001_01111_00001_00010_01100,  // 9
    35'b01110_10001_10001_10001_11111_10001_10001,  // a
    35'b11110_10001_10001_11110_10001_10001_11110,  // b
    35'b01110_10001_10000_10000_10000_10001_01110,  // c
    35'b11100_10010_10001_10001_10001_10010_11100,  // d
    35'b11111_10000_10000_11110_10000_10000_11111,  // e
    35'b11111_10000_10000_11110_10000_10000_10000   // f
  };

endpackage

// ==== btn_conditioner.sv ====
`timescale 1ns/10ps
module btn_conditioner import rtc_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic [6:0] btn,
  output logic [1:0] addr,
  output logic [7:0] di,
  output logic       wr
);

  logic [6:0] btn_m;                  // first sync stage
  logic [6:0] btn_s;                  // second sync stage
  logic [6:0] btn_last;               // synced value one cycle ago
  logic [6:0] btn_db;                 // debounced levels
  logic [$clog2(debounce_len)-1:0] db_cnt;
  logic       accept;

  // sync chain
  always_ff @(posedge clk) begin
    btn_m <= btn;
    btn_s <= btn_m;
  end

  // one counter for all buttons, any change restarts it
  assign accept = (btn_s == btn_last) && (btn_s != btn_db) &&
                  (int'(db_cnt) == debounce_len - 1);

  always_ff @(posedge clk) begin
    if (rst) begin
      btn_last <= '0;
      btn_db   <= '0;
      db_cnt   <= '0;
      wr       <= 1'b0;
    end else begin
      btn_last <= btn_s;
      wr       <= accept && btn_s[6] && !btn_db[6];   // press of the strobe button
      if ((btn_s != btn_last) || (btn_s == btn_db))
        db_cnt <= '0;
      else
        db_cnt <= db_cnt + 1'b1;
      if (accept)
        btn_db <= btn_s;
    end
  end

  assign addr = btn_db[2:1];

  // request byte per register
  always_comb begin
    case (addr)
      reg_cmd:   di = {~btn_db[3], 7'd0};   // bit 7 reads, pressed means write
      reg_dev:   di = {1'b0, dev_addr_rtc};
      reg_raddr: di = 8'h00;                // seconds register
      default:   di = 8'h80;                // st bit starts the oscillator
    endcase
  end

  assert property (@(posedge clk) disable iff (rst) wr |=> !wr)
    else $error("wr held for more than one cycle");

endmodule

// ==== i2c_bit_engine.sv ====
`timescale 1ns/10ps
module i2c_bit_engine import rtc_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic [2:0] cmd,
  input  logic [7:0] tx_byte,
  input  logic       tx_ack,
  input  logic       scl_in,
  input  logic       sda_in,
  output logic       scl_low,
  output logic       sda_low,
  output logic [7:0] rx_byte,
  output logic       rx_ack,
  output logic       done
);

  logic [2:0] op;                             // running command, cmd_idle when free
  logic [$clog2(scl_quarter)-1:0] qcnt;       // cycles into the quarter
  logic [1:0] phase;                          // scl low, high, high, low
  logic [3:0] bit_cnt;                        // 8 is the ack slot
  logic [8:0] tx_sh;                          // msb goes on the wire
  logic       byte_op;
  logic       pin_byte;                       // pins currently carry a byte op
  logic       scl_l_nx;
  logic       sda_l_nx;
  logic       q_end;                          // last cycle of a quarter
  logic       hold;
  logic       step;

  assign byte_op = (op == cmd_write) || (op == cmd_read);
  assign q_end   = (int'(qcnt) == scl_quarter - 1);
  // released scl not yet seen high on the line
  assign hold    = (phase == 2'd1) && !scl_low && !scl_in;
  assign step    = q_end && !hold;

  // pin levels for the current quarter
  always_comb begin
    scl_l_nx = (phase == 2'd0) || (phase == 2'd3);
    sda_l_nx = !tx_sh[8];
    case (op)
      cmd_start: sda_l_nx = phase[1];         // sda falls in the high half
      cmd_stop: begin
        scl_l_nx = (phase == 2'd0);           // scl stays high at the end
        sda_l_nx = !phase[1];                 // sda rises in the high half
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      op       <= cmd_idle;
      qcnt     <= '0;
      phase    <= 2'd0;
      bit_cnt  <= 4'd0;
      scl_low  <= 1'b0;
      sda_low  <= 1'b0;
      pin_byte <= 1'b0;
      done     <= 1'b0;
    end else begin
      done <= 1'b0;
      if (op == cmd_idle) begin
        if (cmd != cmd_idle) begin
          op      <= cmd;
          qcnt    <= '0;
          phase   <= 2'd0;
          bit_cnt <= 4'd0;
        end
      end else begin
        scl_low  <= scl_l_nx;                 // pins hold when idle
        sda_low  <= sda_l_nx;
        pin_byte <= byte_op;
        if (!hold)
          qcnt <= q_end ? '0 : qcnt + 1'b1;
        if (step) begin
          phase <= phase + 2'd1;
          if (phase == 2'd3) begin
            bit_cnt <= bit_cnt + 4'd1;
            if (!byte_op || (bit_cnt == 4'd8)) begin
              op   <= cmd_idle;
              done <= 1'b1;
            end
          end
        end
      end
    end
  end

  // shift data, no reset on the payload
  always_ff @(posedge clk) begin
    if ((op == cmd_idle) && (cmd != cmd_idle))
      tx_sh <= (cmd == cmd_read) ? {8'hFF, !tx_ack} : {tx_byte, 1'b1};
    else if (step && (phase == 2'd3))
      tx_sh <= {tx_sh[7:0], 1'b1};
    if (byte_op && step && (phase == 2'd1)) begin   // middle of scl high
      if (bit_cnt == 4'd8)
        rx_ack <= !sda_in;
      else
        rx_byte <= {rx_byte[6:0], sda_in};
    end
  end

  // sda only moves under a low scl while a byte is on the wire
  assert property (@(posedge clk) disable iff (rst)
    (pin_byte && !scl_low && !$past(scl_low)) |-> $stable(sda_low))
    else $error("sda changed while scl high");

  assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else $error("done longer than one cycle");

endmodule

// ==== i2c_master_8bit.sv ====
`timescale 1ns/10ps
module i2c_master_8bit import rtc_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic [1:0] addr,
  input  logic [7:0] di,
  input  logic       wr,
  output logic [7:0] dout,
  output logic       busy,
  output logic       ack_err,
  output logic       scl_low,
  output logic       sda_low,
  input  logic       scl_in,
  input  logic       sda_in
);

  logic [7:0] r_wdata;
  logic [7:0] r_raddr;
  logic [7:0] r_dev;
  logic [7:0] r_rx;                   // last byte read from the chip
  logic       rd;                     // running transaction is a read
  logic [3:0] state;
  logic       pend;                   // command out, waiting for done
  logic [2:0] eng_cmd;
  logic [7:0] eng_tx;
  logic       eng_busy;               // engine mid-command as seen from here
  logic [7:0] rx_byte;
  logic       rx_ack;
  logic       done;
  logic       ack_slot;               // step ends in a slave ack
  i2c_addr_byte_u addr_byte;

  assign busy     = (state != st_idle);
  assign ack_slot = (state == st_addr_w) || (state == st_reg) ||
                    (state == st_data_w) || (state == st_addr_r);

  always_comb begin
    addr_byte.f.dev = r_dev[6:0];
    addr_byte.f.rw  = (state == st_addr_r);   // second address turns the bus
  end

  always_comb begin
    case (state)
      st_reg:    eng_tx = r_raddr;
      st_data_w: eng_tx = r_wdata;
      default:   eng_tx = addr_byte.raw;
    endcase
  end

  // register readback
  always_comb begin
    case (addr)
      reg_wdata: dout = r_rx;
      reg_raddr: dout = r_raddr;
      reg_dev:   dout = r_dev;
      default:   dout = {busy, ack_err, 6'd0};
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      r_wdata  <= 8'h00;
      r_raddr  <= 8'h00;
      r_dev    <= 8'h00;
      r_rx     <= 8'h00;
      rd       <= 1'b0;
      state    <= st_idle;
      pend     <= 1'b0;
      ack_err  <= 1'b0;
      eng_cmd  <= cmd_idle;
      eng_busy <= 1'b0;
    end else begin
      eng_cmd  <= cmd_idle;             // one-cycle command
      eng_busy <= (eng_busy && !done) || (eng_cmd != cmd_idle);
      if (wr) begin
        case (addr)
          reg_wdata: r_wdata <= di;
          reg_raddr: r_raddr <= di;
          reg_dev:   r_dev   <= di;
          default: if (!busy) begin     // cmd while busy is dropped
            rd      <= di[7];
            state   <= st_start;
            ack_err <= 1'b0;
          end
        endcase
      end
      if (busy && !pend) begin
        pend <= 1'b1;
        case (state)
          st_start, st_rstart: eng_cmd <= cmd_start;
          st_stop:             eng_cmd <= cmd_stop;
          st_data_r:           eng_cmd <= cmd_read;
          default:             eng_cmd <= cmd_write;
        endcase
      end else if (pend && done) begin
        pend <= 1'b0;
        if (ack_slot && !rx_ack) begin  // nack, straight to stop
          ack_err <= 1'b1;
          state   <= st_stop;
        end else begin
          case (state)
            st_start:  state <= st_addr_w;
            st_addr_w: state <= st_reg;
            st_reg:    state <= rd ? st_rstart : st_data_w;
            st_data_w: state <= st_stop;
            st_rstart: state <= st_addr_r;
            st_addr_r: state <= st_data_r;
            st_data_r: begin
              r_rx  <= rx_byte;
              state <= st_stop;
            end
            default:   state <= st_idle;
          endcase
        end
      end
    end
  end

  i2c_bit_engine bit_engine_inst (
    .clk     (clk),
    .rst     (rst),
    .cmd     (eng_cmd),
    .tx_byte (eng_tx),
    .tx_ack  (1'b0),                    // single read byte always ends in nack
    .scl_in  (scl_in),
    .sda_in  (sda_in),
    .scl_low (scl_low),
    .sda_low (sda_low),
    .rx_byte (rx_byte),
    .rx_ack  (rx_ack),
    .done    (done)
  );

  assert property (@(posedge clk) disable iff (rst) (eng_cmd != cmd_idle) |-> !eng_busy)
    else $error("command issued while bit engine busy");

endmodule

// ==== hex_pixel_render.sv ====
`timescale 1ns/10ps
module hex_pixel_render import rtc_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic [63:0] data,
  input  logic [7:0]  x,
  input  logic [7:0]  y,
  output logic [15:0] color
);

  logic [7:0]  digit;                 // cell index along x
  logic [7:0]  col;                   // pixel column in the cell
  logic [2:0]  row;
  logic [3:0]  nibble;
  logic [34:0] glyph;
  logic [5:0]  bit_idx;
  logic        in_glyph;
  logic        pixel_on;

  always_comb begin
    digit  = 8'(int'(x) / cell_w);
    col    = 8'(int'(x) % cell_w);
    row    = y[2:0];
    nibble = data[4 * (15 - int'(digit[3:0])) +: 4];   // digit 0 is the top nibble
    glyph  = hex_glyph[nibble];
    // blank spacing column, bottom row, past 16 digits, below the text line
    in_glyph = (int'(digit) < 16) && (int'(col) < glyph_w) &&
               (int'(row) < glyph_h) && (int'(y) < cell_h);
    bit_idx  = in_glyph ?
               6'(glyph_w * glyph_h - 1 - glyph_w * int'(row) - int'(col)) : 6'd0;
    pixel_on = in_glyph && glyph[bit_idx];
  end

  // one clock behind x and y
  always_ff @(posedge clk) begin
    if (rst)
      color <= color_bg;
    else
      color <= pixel_on ? color_fg : color_bg;
  end

endmodule

// ==== rtc_panel_top.sv ====
`timescale 1ns/10ps
module rtc_panel_top (
  input  logic        clk,
  input  logic        rst,
  input  logic [6:0]  btn,
  output logic [7:0]  led,
  output logic        scl_low,
  output logic        sda_low,
  input  logic        scl_in,
  input  logic        sda_in,
  input  logic [7:0]  x,
  input  logic [7:0]  y,
  output logic [15:0] color
);

  logic [1:0]  addr;                  // register select from the buttons
  logic [7:0]  di;
  logic        wr;
  logic [7:0]  dout;
  logic [63:0] display;               // 16 hex digits on screen

  btn_conditioner btn_inst (
    .clk  (clk),
    .rst  (rst),
    .btn  (btn),
    .addr (addr),
    .di   (di),
    .wr   (wr)
  );

  // busy and ack_err show up on register 3
  i2c_master_8bit i2c_inst (
    .clk     (clk),
    .rst     (rst),
    .addr    (addr),
    .di      (di),
    .wr      (wr),
    .dout    (dout),
    .busy    (),
    .ack_err (),
    .scl_low (scl_low),
    .sda_low (sda_low),
    .scl_in  (scl_in),
    .sda_in  (sda_in)
  );

  // raw strobe button, register select, request and readback
  assign display = {44'd0, btn[6], 1'b0, addr, di, dout};
  assign led     = dout;

  hex_pixel_render render_inst (
    .clk   (clk),
    .rst   (rst),
    .data  (display),
    .x     (x),
    .y     (y),
    .color (color)
  );

endmodule

// ==== tb_rtc_slave_model.sv ====
`timescale 1ns/10ps
module tb_rtc_slave_model import rtc_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       scl,               // resolved bus lines
  input  logic       sda,
  input  logic       ack_en,            // 0 leaves every byte without ack
  input  logic       load_en,           // backdoor write into the register memory
  input  logic [7:0] load_addr,
  input  logic [7:0] load_data,
  input  logic [7:0] peek_addr,
  output logic [7:0] peek_data,
  output logic [6:0] dev_seen,          // device field of the last address byte
  output logic       sda_low
);

  typedef enum logic [1:0] {stg_addr, stg_reg, stg_wdata, stg_rdata} stage_t;

  logic [7:0] mem [256];                // chip registers, seconds at 0
  logic [7:0] sh;                       // byte shifting in or out
  logic [3:0] cnt;                      // scl rises in the current frame, 9th is ack
  logic [7:0] ptr;                      // register pointer
  logic       active;                   // addressed and taking part
  logic       tx;                       // chip drives data
  logic       m_ack;                    // ack from the master after a read byte
  logic       scl_q;
  logic       sda_q;
  logic       start_c;
  logic       stop_c;
  logic       scl_rise;
  logic       scl_fall;
  logic       wr_mem;
  stage_t     stage;
  i2c_addr_byte_u addr_in;              // received address byte

  assign start_c  = scl && scl_q && sda_q && !sda;   // sda falls under high scl
  assign stop_c   = scl && scl_q && !sda_q && sda;
  assign scl_rise = scl && !scl_q;
  assign scl_fall = !scl && scl_q;
  assign peek_data = mem[peek_addr];

  always_comb addr_in.raw = sh;

  // data byte complete and accepted
  assign wr_mem = active && !tx && scl_fall && (cnt == 4'd8) &&
                  (stage == stg_wdata) && ack_en;

  always_ff @(posedge clk) begin
    if (load_en)
      mem[load_addr] <= load_data;
    else if (wr_mem)
      mem[ptr] <= sh;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      scl_q    <= 1'b1;
      sda_q    <= 1'b1;
      active   <= 1'b0;
      tx       <= 1'b0;
      cnt      <= 4'd0;
      ptr      <= 8'd0;
      stage    <= stg_addr;
      sda_low  <= 1'b0;
      dev_seen <= 7'd0;
      m_ack    <= 1'b0;
    end else begin
      scl_q <= scl;
      sda_q <= sda;
      if (start_c) begin                // start or repeated start
        active  <= 1'b1;
        tx      <= 1'b0;
        cnt     <= 4'd0;
        stage   <= stg_addr;
        sda_low <= 1'b0;
      end else if (stop_c) begin
        active  <= 1'b0;
        tx      <= 1'b0;
        sda_low <= 1'b0;
      end else if (active && scl_rise) begin
        if (!tx && (cnt < 4'd8))
          sh <= {sh[6:0], sda};         // msb first
        if (tx && (cnt == 4'd8))
          m_ack <= !sda;
        cnt <= cnt + 4'd1;
      end else if (active && scl_fall) begin
        if (tx) begin
          if (cnt < 4'd8) begin
            sh      <= {sh[6:0], 1'b1};
            sda_low <= !sh[6];          // next bit
          end else if (cnt == 4'd8) begin
            sda_low <= 1'b0;            // master's ack slot
          end else begin
            cnt <= 4'd0;
            if (m_ack) begin            // burst continues
              ptr     <= ptr + 8'd1;
              sh      <= mem[ptr + 8'd1];
              sda_low <= !mem[ptr + 8'd1][7];
            end else begin
              active <= 1'b0;           // nack, wait for stop
              tx     <= 1'b0;
            end
          end
        end else if (cnt == 4'd8) begin
          sda_low <= ack_en;            // ack under low scl
          case (stage)
            stg_addr: begin
              dev_seen <= addr_in.f.dev;
              if (addr_in.f.dev != dev_addr_rtc)
                sda_low <= 1'b0;        // not this chip
            end
            stg_reg:   ptr <= sh;
            stg_wdata: if (ack_en) ptr <= ptr + 8'd1;
            default: ;
          endcase
        end else if (cnt == 4'd9) begin
          sda_low <= 1'b0;
          cnt     <= 4'd0;
          if (!sda_low) begin
            active <= 1'b0;             // byte refused
          end else begin
            case (stage)
              stg_addr: begin
                if (addr_in.f.rw) begin // read turns the bus around here
                  tx      <= 1'b1;
                  stage   <= stg_rdata;
                  sh      <= mem[ptr];
                  sda_low <= !mem[ptr][7];
                end else begin
                  stage <= stg_reg;
                end
              end
              stg_reg: stage <= stg_wdata;
              default: ;
            endcase
          end
        end
      end
    end
  end

endmodule

// ==== tb_rtc_panel.sv ====
`timescale 1ns/10ps
module tb_rtc_panel import rtc_pkg::*; ();

  localparam int settle_cycles = debounce_len + 16;   // sync, debounce and margin
  localparam int txn_cycles    = 50 * 4 * scl_quarter; // one transaction, generous
  localparam int limit_cycles  = 6 * txn_cycles + 40 * settle_cycles + 4096;

  logic        clk;
  logic        rst;
  logic [6:0]  btn;
  logic [7:0]  x;
  logic [7:0]  y;
  logic [7:0]  led;
  logic [15:0] color;
  logic        scl_low;
  logic        sda_low;
  logic        scl_line;
  logic        sda_line;
  logic        chip_sda_low;
  logic        ack_en;
  logic        load_en;
  logic [7:0]  load_addr;
  logic [7:0]  load_data;
  logic [7:0]  chip_byte0;
  logic [6:0]  dev_seen;
  int          tests_run;
  int          checks_done;
  int          err_total;
  int          test_errs;

  // wired and, the chip model never holds scl
  assign scl_line = !scl_low;
  assign sda_line = !sda_low && !chip_sda_low;

  rtc_panel_top dut (
    .clk     (clk),
    .rst     (rst),
    .btn     (btn),
    .led     (led),
    .scl_low (scl_low),
    .sda_low (sda_low),
    .scl_in  (scl_line),
    .sda_in  (sda_line),
    .x       (x),
    .y       (y),
    .color   (color)
  );

  tb_rtc_slave_model rtc_chip (
    .clk       (clk),
    .rst       (rst),
    .scl       (scl_line),
    .sda       (sda_line),
    .ack_en    (ack_en),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .peek_addr (8'h00),               // seconds byte only
    .peek_data (chip_byte0),
    .dev_seen  (dev_seen),
    .sda_low   (chip_sda_low)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    repeat (limit_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, run stopped", limit_cycles);
    $display("test failed");
    $finish;
  end

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    checks_done++;
    if (got !== exp) begin
      test_errs++;
      $display("** Error at %0t: %s got %02h expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic check_color(input logic [15:0] got, input logic [15:0] exp,
                             input string what);
    checks_done++;
    if (got !== exp) begin
      test_errs++;
      $display("** Error at %0t: %s got %04h expected %04h", $time, what, got, exp);
    end
  endtask

  // strobe btn[6], write flag btn[3], register select btn[2:1]
  function automatic logic [6:0] btn_word(logic [1:0] a, logic wflag, logic strobe);
    return {strobe, 2'b00, wflag, a, 1'b0};
  endfunction

  function automatic logic [7:0] request_byte(logic [1:0] a, logic wflag);
    case (a)
      2'd3:    return {~wflag, 7'd0};  // read unless write held
      2'd2:    return {1'b0, dev_addr_rtc};
      2'd1:    return 8'h00;
      default: return 8'h80;
    endcase
  endfunction

  // 5x7 glyph in a 6x8 cell, digit 0 is the top nibble
  function automatic logic [15:0] expected_color(logic [63:0] word, int px, int py);
    int digit;
    int col;
    int idx;
    logic [3:0] nib;
    digit = px / cell_w;
    col   = px % cell_w;
    if ((digit >= 16) || (col >= glyph_w) || (py >= glyph_h))
      return color_bg;
    nib = word[63 - 4 * digit -: 4];
    idx = glyph_w * glyph_h - 1 - glyph_w * py - col;    // top row in the msbs
    return hex_glyph[nib][idx] ? color_fg : color_bg;
  endfunction

  task automatic set_buttons(input logic [6:0] val);
    @(negedge clk);
    btn = val;
    repeat (settle_cycles) @(negedge clk);
  endtask

  task automatic press(input logic [1:0] a, input logic wflag);
    set_buttons(btn_word(a, wflag, 1'b1));
    set_buttons(btn_word(a, wflag, 1'b0));
  endtask

  task automatic load_chip(input logic [7:0] a, input logic [7:0] d);
    @(negedge clk);
    load_en   = 1'b1;
    load_addr = a;
    load_data = d;
    @(negedge clk);
    load_en = 1'b0;
  endtask

  // select must be on the status register
  task automatic wait_idle();
    int n;
    n = 0;
    while ((led[7] !== 1'b0) && (n < txn_cycles)) begin
      @(negedge clk);
      n++;
    end
    if (led[7] !== 1'b0) begin
      test_errs++;
      $display("transaction still busy after %0d cycles at %0t", n, $time);
    end
  endtask

  task automatic report_test(input string name);
    if (test_errs == 0)
      $display("%-20s ok", name);
    else
      $display("%-20s %0d errors", name, test_errs);
    err_total += test_errs;
    test_errs = 0;
    tests_run++;
  endtask

  task automatic test_reset_status();
    check_byte(led, 8'h00, "rx byte after reset");
    check_byte({6'd0, scl_low, sda_low}, 8'h00, "bus released after reset");
    check_color(color, color_bg, "color after reset");
    set_buttons(btn_word(reg_cmd, 1'b0, 1'b0));
    check_byte(led, 8'h00, "idle status");
    check_byte({6'd0, scl_low, sda_low}, 8'h00, "no bus activity while idle");
    press(reg_cmd, 1'b0);             // starts a read with no device set
    check_byte(led & 8'h80, 8'h80, "busy bit");
    report_test("reset and status");
  endtask

  task automatic test_write();
    wait_idle();                      // read left over from the status test
    press(reg_wdata, 1'b0);
    press(reg_raddr, 1'b0);
    press(reg_dev, 1'b0);
    press(reg_cmd, 1'b1);
    wait_idle();
    check_byte(chip_byte0, 8'h80, "chip seconds byte");
    check_byte({1'b0, dev_seen}, {1'b0, dev_addr_rtc}, "device address on bus");
    check_byte(led, 8'h00, "status after write");
    report_test("register write");
  endtask

  task automatic test_read();
    logic [7:0] val;
    val = 8'($urandom);
    load_chip(8'h00, val);
    press(reg_cmd, 1'b0);
    wait_idle();
    check_byte(led, 8'h00, "status after read");
    set_buttons(btn_word(reg_wdata, 1'b0, 1'b0));
    check_byte(led, val, "byte read from chip");
    report_test("register read");
  endtask

  task automatic test_nack();
    logic [7:0] val;
    val = {1'b0, 7'($urandom)};       // never the write pattern
    load_chip(8'h00, val);
    @(negedge clk);
    ack_en = 1'b0;
    press(reg_cmd, 1'b1);
    wait_idle();
    check_byte(led, 8'h40, "status after nack");
    check_byte(chip_byte0, val, "chip byte after nack");
    @(negedge clk);
    ack_en = 1'b1;
    report_test("missing ack");
  endtask

  task automatic test_debounce();
    set_buttons(7'd0);
    @(negedge clk);
    rst = 1'b1;                       // back to cleared registers
    repeat (2) @(negedge clk);
    rst = 1'b0;
    set_buttons(btn_word(reg_dev, 1'b0, 1'b0));
    check_byte(led, 8'h00, "dev register after reset");
    btn = btn_word(reg_dev, 1'b0, 1'b1);
    repeat (debounce_len / 2) @(negedge clk);   // short bounce
    btn = btn_word(reg_dev, 1'b0, 1'b0);
    repeat (settle_cycles) @(negedge clk);
    check_byte(led, 8'h00, "dev register after glitch");
    set_buttons(btn_word(reg_raddr, 1'b0, 1'b0));
    check_byte(led, 8'h00, "read address after glitch");
    press(reg_dev, 1'b0);
    check_byte(led, {1'b0, dev_addr_rtc}, "dev register after full press");
    report_test("debounce");
  endtask

  task automatic test_display();
    logic [63:0] word;
    logic [7:0]  led_known;
    set_buttons(btn_word(reg_dev, 1'b0, 1'b1));  // strobe held down
    led_known = {1'b0, dev_addr_rtc};
    check_byte(led, led_known, "led under display");
    word = {44'd0, btn[6], 1'b0, btn[2:1], request_byte(btn[2:1], btn[3]), led_known};
    for (int py = 0; py < 10; py++) begin
      for (int px = 0; px < 104; px++) begin
        x = 8'(px);
        y = 8'(py);
        @(negedge clk);               // registered one clock later
        check_color(color, expected_color(word, px, py), $sformatf("pixel %0d,%0d", px, py));
      end
    end
    for (int px = 60; px < 80; px++) begin
      x = 8'(px);
      y = 8'd200;                     // far below the text line
      @(negedge clk);
      check_color(color, color_bg, $sformatf("pixel %0d,200", px));
    end
    report_test("display");
  endtask

  initial begin
    void'($urandom(32'h606d_493b));
    rst         = 1'b1;
    btn         = 7'd0;
    x           = 8'd0;
    y           = 8'd0;
    ack_en      = 1'b1;
    load_en     = 1'b0;
    load_addr   = 8'd0;
    load_data   = 8'd0;
    tests_run   = 0;
    checks_done = 0;
    err_total   = 0;
    test_errs   = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < 256; i++)
      load_chip(8'(i), 8'($urandom));   // random chip contents

    test_reset_status();
    test_write();
    test_read();
    test_nack();
    test_debounce();
    test_display();

    $display("tests %0d, checks %0d, errors %0d", tests_run, checks_done, err_total);
    if (err_total == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

// ==== src.f ====
rtc_pkg.sv
btn_conditioner.sv
i2c_bit_engine.sv
i2c_master_8bit.sv
hex_pixel_render.sv
rtc_panel_top.sv
tb_rtc_slave_model.sv
tb_rtc_panel.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the rtc panel testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_rtc_panel -f src.f -o sim_rtc_panel

./obj_dir/sim_rtc_panel > sim.log 2>&1
cat sim.log

if grep -q "test failed" sim.log; then
  exit 1
fi
grep -q "test passed" sim.log
